/* flist.f */
isa_pkg.sv
pipe_pkg.sv
stage_ifs.sv
control_unit.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_core.sv
tb_mips_core.sv

/* tb_mips_core.sv */
`timescale 1ns/100ps

module tb_mips_core;

    typedef logic [isa_pkg::XLEN-1:0]   word_t;
    typedef logic [isa_pkg::NB_REG-1:0] reg_t;

    logic  i_clk;
    logic  i_rst_n;
    logic  i_instr_valid;
    word_t i_instr;
    logic  o_wb_valid;
    reg_t  o_wb_reg;
    word_t o_wb_data;

    word_t ref_regs [isa_pkg::NUM_REGS];
    logic [7:0] ref_mem [pipe_pkg::DMEM_WORDS*4];   // byte image of data memory

    reg_t  exp_reg[$];
    word_t exp_data[$];
    int    exp_cyc[$];
    reg_t  obs_reg[$];
    word_t obs_data[$];
    int    obs_cyc[$];

    int cyc      = 0;
    int errors   = 0;
    int n_checks = 0;
    int n_tests  = 0;
    int n_issued = 0;

    mips_core u_mips_core (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_wb_valid    (o_wb_valid),
        .o_wb_reg      (o_wb_reg),
        .o_wb_data     (o_wb_data)
    );

    initial i_clk = 1'b0;
    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) cyc <= cyc + 1;

    // outputs are sampled mid-cycle, well away from the rising edge
    always @(negedge i_clk) begin
        if (o_wb_valid === 1'b1) begin
            obs_reg.push_back(o_wb_reg);
            obs_data.push_back(o_wb_data);
            obs_cyc.push_back(cyc);
        end
    end

    // ************************************************************************
    // instruction encoding and reference model
    // ************************************************************************
    function automatic word_t rtype_word(isa_pkg::funct_e fn, reg_t rd, reg_t rs, reg_t rt,
                                         logic [4:0] sh);
        return {isa_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype_word(isa_pkg::opcode_e op, reg_t rt, reg_t rs,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic model_instr(input word_t instr, output bit wr, output reg_t dst,
                               output word_t val);
        isa_pkg::opcode_e op;
        word_t a;
        word_t b;
        word_t simm;
        word_t zimm;
        word_t addr;
        int    bi;
        int    bw;
        op   = isa_pkg::opcode_e'(instr[31:26]);
        a    = ref_regs[instr[25:21]];
        b    = ref_regs[instr[20:16]];
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0000, instr[15:0]};
        addr = a + simm;
        bi   = int'(addr[pipe_pkg::DMEM_AW+1:0]);   // byte offset wraps on memory size
        bw   = bi & ~3;
        wr   = 1'b1;
        dst  = instr[20:16];
        val  = '0;
        case (op)
            isa_pkg::OP_RTYPE: begin
                dst = instr[15:11];
                case (isa_pkg::funct_e'(instr[5:0]))
                    isa_pkg::FN_ADD: val = a + b;
                    isa_pkg::FN_SUB: val = a - b;
                    isa_pkg::FN_AND: val = a & b;
                    isa_pkg::FN_OR:  val = a | b;
                    isa_pkg::FN_XOR: val = a ^ b;
                    isa_pkg::FN_NOR: val = ~(a | b);
                    isa_pkg::FN_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    isa_pkg::FN_SLL: val = b << instr[10:6];
                    isa_pkg::FN_SRL: val = b >> instr[10:6];
                    default:         wr = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDI: val = a + simm;
            isa_pkg::OP_SLTI: val = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            isa_pkg::OP_ANDI: val = a & zimm;
            isa_pkg::OP_ORI:  val = a | zimm;
            isa_pkg::OP_XORI: val = a ^ zimm;
            isa_pkg::OP_LUI:  val = {instr[15:0], 16'h0000};
            isa_pkg::OP_LB:   val = {{24{ref_mem[bi][7]}}, ref_mem[bi]};
            isa_pkg::OP_LBU:  val = {24'h000000, ref_mem[bi]};
            isa_pkg::OP_LW: begin
                for (int i = 0; i < 4; i++) begin
                    val[8*i +: 8] = ref_mem[bw + i];
                end
            end
            isa_pkg::OP_SW: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[bw + i] = b[8*i +: 8];
                end
                wr = 1'b0;
            end
            isa_pkg::OP_SB: begin
                ref_mem[bi] = b[7:0];
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (dst == '0) wr = 1'b0;
        if (wr) ref_regs[dst] = val;
    endtask

    // ************************************************************************
    // stimulus and checking
    // ************************************************************************
    task automatic issue(input word_t instr);
        bit    wr;
        reg_t  dst;
        word_t val;
        @(negedge i_clk);
        i_instr_valid = 1'b1;
        i_instr       = instr;
        n_issued++;
        model_instr(instr, wr, dst, val);
        if (wr) begin
            exp_reg.push_back(dst);
            exp_data.push_back(val);
            exp_cyc.push_back(cyc + 3);   // result shows three cycles after the strobe
        end
    endtask

    task automatic pad(input int n);
        repeat (n) begin
            @(negedge i_clk);
            i_instr_valid = 1'b0;
        end
    endtask

    task automatic run(input word_t instr);
        issue(instr);
        pad(2);
    endtask

    task automatic load_reg(input reg_t r, input word_t value);
        run(itype_word(isa_pkg::OP_LUI, r, 5'd0, value[31:16]));
        run(itype_word(isa_pkg::OP_ORI, r, r, value[15:0]));
    endtask

    task automatic check_wb(input string name, input reg_t exp_r, input word_t exp_d,
                            input reg_t act_r, input word_t act_d);
        n_checks++;
        if (exp_r !== act_r || exp_d !== act_d) begin
            $display("error %s: expected r%0d=%h actual r%0d=%h",
                     name, exp_r, exp_d, act_r, act_d);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input int exp_c, input int act_c);
        n_checks++;
        if (exp_c != act_c) begin
            $display("error %s: writeback cycle expected %0d actual %0d", name, exp_c, act_c);
            errors++;
        end
    endtask

    task automatic settle(input string name, input int start);
        reg_t  r;
        word_t d;
        int    c;
        pad(6);
        @(posedge i_clk);
        while (exp_reg.size() > 0) begin
            r = exp_reg.pop_front();
            d = exp_data.pop_front();
            c = exp_cyc.pop_front();
            if (obs_reg.size() == 0) begin
                $display("%s: a writeback to r%0d was expected but never came", name, r);
                errors++;
            end else begin
                check_wb(name, r, d, obs_reg.pop_front(), obs_data.pop_front());
                check_latency(name, c, obs_cyc.pop_front());
            end
        end
        while (obs_reg.size() > 0) begin
            $display("%s: unexpected writeback to r%0d with %h", name, obs_reg[0], obs_data[0]);
            errors++;
            void'(obs_reg.pop_front());
            void'(obs_data.pop_front());
            void'(obs_cyc.pop_front());
        end
        n_tests++;
        $display("test %s: %s", name, (errors == start) ? "ok" : "failed");
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************
    task automatic rtype_test();
        int         start;
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        start = errors;
        a  = $urandom() | 32'h8000_0000;   // negative
        b  = $urandom() & 32'h7fff_ffff;   // positive
        sh = 5'($urandom_range(31, 1));
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        run(rtype_word(isa_pkg::FN_ADD, 5'd10, 5'd1, 5'd2, 5'd0));
        run(rtype_word(isa_pkg::FN_SUB, 5'd11, 5'd1, 5'd2, 5'd0));
        run(rtype_word(isa_pkg::FN_AND, 5'd12, 5'd1, 5'd2, 5'd0));
        run(rtype_word(isa_pkg::FN_OR,  5'd13, 5'd1, 5'd2, 5'd0));
        run(rtype_word(isa_pkg::FN_XOR, 5'd14, 5'd1, 5'd2, 5'd0));
        run(rtype_word(isa_pkg::FN_NOR, 5'd15, 5'd1, 5'd2, 5'd0));
        run(rtype_word(isa_pkg::FN_SLT, 5'd16, 5'd1, 5'd2, 5'd0));
        run(rtype_word(isa_pkg::FN_SLT, 5'd17, 5'd2, 5'd1, 5'd0));
        run(rtype_word(isa_pkg::FN_SLL, 5'd18, 5'd0, 5'd1, sh));
        run(rtype_word(isa_pkg::FN_SRL, 5'd19, 5'd0, 5'd1, sh));
        settle("rtype", start);
    endtask

    task automatic imm_test();
        int start;
        start = errors;
        load_reg(5'd3, $urandom());
        run(itype_word(isa_pkg::OP_ADDI, 5'd20, 5'd3, 16'hfff0));
        run(itype_word(isa_pkg::OP_ADDI, 5'd21, 5'd3, 16'h1234));
        run(itype_word(isa_pkg::OP_SLTI, 5'd22, 5'd3, 16'h8000));
        run(itype_word(isa_pkg::OP_SLTI, 5'd23, 5'd0, 16'hffff));
        run(itype_word(isa_pkg::OP_SLTI, 5'd24, 5'd0, 16'h0001));
        run(itype_word(isa_pkg::OP_ANDI, 5'd25, 5'd3, 16'hf0f0));
        run(itype_word(isa_pkg::OP_ORI,  5'd26, 5'd3, 16'h8421));
        run(itype_word(isa_pkg::OP_XORI, 5'd27, 5'd3, 16'hffff));
        run(itype_word(isa_pkg::OP_LUI,  5'd28, 5'd0, 16'h8001));
        settle("immediate", start);
    endtask

    task automatic mem_test();
        int         start;
        word_t      base;
        logic [7:0] bval;
        start = errors;
        base = word_t'(pipe_pkg::DMEM_WORDS * 4 * 3 + 32'h40);   // past the top, so it wraps
        load_reg(5'd4, base);
        load_reg(5'd5, $urandom());
        run(itype_word(isa_pkg::OP_SW, 5'd5, 5'd4, 16'h0000));
        run(itype_word(isa_pkg::OP_LW, 5'd6, 5'd4, 16'h0000));
        run(itype_word(isa_pkg::OP_LW, 5'd7, 5'd4, 16'(pipe_pkg::DMEM_WORDS * 4)));
        for (int lane = 0; lane < 4; lane++) begin
            bval = 8'($urandom_range(255, 0));
            if (lane == 2) bval = bval | 8'h80;
            run(itype_word(isa_pkg::OP_ORI, 5'd8, 5'd0, {8'h00, bval}));
            run(itype_word(isa_pkg::OP_SB, 5'd8, 5'd4, 16'(4 + lane)));
        end
        run(itype_word(isa_pkg::OP_LW,  5'd9,  5'd4, 16'h0004));
        run(itype_word(isa_pkg::OP_LB,  5'd10, 5'd4, 16'h0006));
        run(itype_word(isa_pkg::OP_LBU, 5'd11, 5'd4, 16'h0006));
        run(itype_word(isa_pkg::OP_LW,  5'd12, 5'd4, 16'hff04));
        settle("memory", start);
    endtask

    task automatic noeffect_test();
        int start;
        start = errors;
        run(itype_word(isa_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0005));
        run(rtype_word(isa_pkg::FN_ADD, 5'd0, 5'd1, 5'd2, 5'd0));
        run(itype_word(isa_pkg::OP_SW, 5'd1, 5'd4, 16'h0010));
        run(itype_word(isa_pkg::OP_SB, 5'd1, 5'd4, 16'h0011));
        run(itype_word(isa_pkg::OP_BEQ, 5'd1, 5'd1, 16'h0004));
        run(itype_word(isa_pkg::OP_BNE, 5'd2, 5'd1, 16'h0004));
        run({isa_pkg::OP_J, 26'h0000123});
        run({6'h3f, 5'd1, 5'd13, 16'h0001});   // opcode not in the ISA
        run(rtype_word(isa_pkg::funct_e'(6'h3f), 5'd13, 5'd1, 5'd2, 5'd0));
        run(rtype_word(isa_pkg::FN_OR, 5'd13, 5'd0, 5'd0, 5'd0));
        run(itype_word(isa_pkg::OP_ADDI, 5'd14, 5'd0, 16'h0007));
        settle("no_effect", start);
    endtask

    task automatic pipeline_test();
        int start;
        start = errors;
        for (int k = 0; k < 5; k++) begin
            issue(itype_word(isa_pkg::OP_ADDI, reg_t'(20 + k), 5'd0, 16'($urandom())));
        end
        pad(2);
        issue(rtype_word(isa_pkg::FN_ADD, 5'd25, 5'd24, 5'd20, 5'd0));   // needs r24 from 3 back
        settle("pipeline", start);
    endtask

    initial begin
        void'($urandom(55));
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        rtype_test();
        imm_test();
        mem_test();
        noeffect_test();
        pipeline_test();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // limit grows with every instruction issued
    initial begin
        while (cyc <= n_issued * 10 + 200) begin
            @(posedge i_clk);
        end
        $display("watchdog: the run did not finish within %0d cycles", cyc);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* mips_core.sv */
`timescale 1ns/100ps

module mips_core (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_instr_valid,
    input  logic [isa_pkg::XLEN-1:0]   i_instr,
    output logic                       o_wb_valid,
    output logic [isa_pkg::NB_REG-1:0] o_wb_reg,
    output logic [isa_pkg::XLEN-1:0]   o_wb_data
);

    dx_if dx ();
    xm_if xm ();
    wb_if wb ();

    decode_stage u_decode_stage (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_dx          (dx.src),
        .i_wb          (wb.dst)
    );

    execute_stage u_execute_stage (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_dx    (dx.dst),
        .o_xm    (xm.src)
    );

    memory_stage u_memory_stage (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_xm    (xm.dst),
        .o_wb    (wb.src)
    );

    // only real register updates show on the ports
    assign o_wb_valid = wb.valid && wb.reg_write && (wb.dest != '0);
    assign o_wb_reg   = wb.dest;
    assign o_wb_data  = wb.data;

endmodule

/* memory_stage.sv */
`timescale 1ns/100ps

module memory_stage (
    input  logic i_clk,
    input  logic i_rst_n,
    xm_if.dst    i_xm,
    wb_if.src    o_wb
);

    logic [isa_pkg::XLEN-1:0]     dmem [pipe_pkg::DMEM_WORDS];
    logic [pipe_pkg::DMEM_AW-1:0] waddr;
    logic [1:0]                   lane;
    logic [isa_pkg::XLEN-1:0]     rd_word;
    logic [7:0]                   rd_byte;
    logic [isa_pkg::XLEN-1:0]     load_data;

    assign waddr   = i_xm.result[pipe_pkg::DMEM_AW+1:2];   // word bits, wraps on depth
    assign lane    = i_xm.result[1:0];
    assign rd_word = dmem[waddr];
    assign rd_byte = rd_word[8*lane +: 8];

    always_comb begin
        if (i_xm.size == pipe_pkg::SIZE_WORD) begin
            load_data = rd_word;
        end else begin
            load_data = {{(isa_pkg::XLEN-8){i_xm.signed_load & rd_byte[7]}}, rd_byte};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_xm.valid && i_xm.mem_write) begin
            if (i_xm.size == pipe_pkg::SIZE_WORD) begin
                dmem[waddr] <= i_xm.store_data;
            end else begin
                dmem[waddr][8*lane +: 8] <= i_xm.store_data[7:0];   // little-endian lane
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb.valid <= 1'b0;
        end else begin
            o_wb.valid <= i_xm.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb.reg_write <= i_xm.reg_write;
        o_wb.dest      <= i_xm.dest;
        o_wb.data      <= i_xm.mem_read ? load_data : i_xm.result;
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
    input  logic i_clk,
    input  logic i_rst_n,
    dx_if.dst    i_dx,
    xm_if.src    o_xm
);

    logic [isa_pkg::XLEN-1:0] alu_a;
    logic [isa_pkg::XLEN-1:0] alu_b;
    logic [isa_pkg::XLEN-1:0] alu_res;
    logic                     slt_bit;

    assign alu_a   = i_dx.op_a;
    assign alu_b   = i_dx.alu_src_imm ? i_dx.imm : i_dx.op_b;
    assign slt_bit = $signed(alu_a) < $signed(alu_b);

    // loads and stores come through as ALU_ADD, giving the effective address
    always_comb begin
        case (i_dx.alu_op)
            pipe_pkg::ALU_ADD:      alu_res = alu_a + alu_b;
            pipe_pkg::ALU_SUB:      alu_res = alu_a - alu_b;
            pipe_pkg::ALU_AND:      alu_res = alu_a & alu_b;
            pipe_pkg::ALU_OR:       alu_res = alu_a | alu_b;
            pipe_pkg::ALU_XOR:      alu_res = alu_a ^ alu_b;
            pipe_pkg::ALU_NOR:      alu_res = ~(alu_a | alu_b);
            pipe_pkg::ALU_SLT:      alu_res = {{(isa_pkg::XLEN-1){1'b0}}, slt_bit};
            pipe_pkg::ALU_SLL:      alu_res = alu_b << i_dx.shamt;   // shifts act on rt
            pipe_pkg::ALU_SRL:      alu_res = alu_b >> i_dx.shamt;
            pipe_pkg::ALU_LUI_PASS: alu_res = alu_b;
            default:                alu_res = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_xm.valid <= 1'b0;
        end else begin
            o_xm.valid <= i_dx.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_xm.result      <= alu_res;
        o_xm.store_data  <= i_dx.op_b;
        o_xm.mem_read    <= i_dx.mem_read;
        o_xm.mem_write   <= i_dx.mem_write;
        o_xm.signed_load <= i_dx.signed_load;
        o_xm.size        <= i_dx.size;
        o_xm.reg_write   <= i_dx.reg_write;
        o_xm.dest        <= i_dx.dest;
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_instr_valid,
    input  logic [isa_pkg::XLEN-1:0] i_instr,
    dx_if.src                        o_dx,
    wb_if.dst                        i_wb
);

    logic [isa_pkg::XLEN-1:0]   regs [isa_pkg::NUM_REGS];
    logic [isa_pkg::NB_REG-1:0] rs;
    logic [isa_pkg::NB_REG-1:0] rt;
    logic [isa_pkg::NB_IMM-1:0] imm16;
    logic [isa_pkg::XLEN-1:0]   rs_data;
    logic [isa_pkg::XLEN-1:0]   rt_data;
    logic [isa_pkg::XLEN-1:0]   imm_ext;
    logic                       wb_write;

    pipe_pkg::alu_op_e          alu_op;
    pipe_pkg::ext_mode_e        ext_mode;
    pipe_pkg::size_e            size;
    logic                       alu_src_imm;
    logic                       mem_read;
    logic                       mem_write;
    logic                       reg_write;
    logic                       signed_load;
    logic [isa_pkg::NB_REG-1:0] dest;

    control_unit u_control_unit (
        .i_instr       (i_instr),
        .o_alu_op      (alu_op),
        .o_alu_src_imm (alu_src_imm),
        .o_mem_read    (mem_read),
        .o_mem_write   (mem_write),
        .o_reg_write   (reg_write),
        .o_signed_load (signed_load),
        .o_ext_mode    (ext_mode),
        .o_size        (size),
        .o_dest        (dest)
    );

    assign rs    = i_instr[25:21];
    assign rt    = i_instr[20:16];
    assign imm16 = i_instr[15:0];

    // ************************************************************************
    // register file, written from writeback and bypassed to reads
    // ************************************************************************
    assign wb_write = i_wb.valid && i_wb.reg_write && (i_wb.dest != '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[i_wb.dest] <= i_wb.data;
        end
    end

    assign rs_data = (rs == '0) ? '0 : (wb_write && i_wb.dest == rs) ? i_wb.data : regs[rs];
    assign rt_data = (rt == '0) ? '0 : (wb_write && i_wb.dest == rt) ? i_wb.data : regs[rt];

    always_comb begin
        case (ext_mode)
            pipe_pkg::EXT_UNSIGNED: imm_ext = {{(isa_pkg::XLEN-isa_pkg::NB_IMM){1'b0}}, imm16};
            pipe_pkg::EXT_SHIFT16L: imm_ext = {imm16, {(isa_pkg::XLEN-isa_pkg::NB_IMM){1'b0}}};
            default:                imm_ext = {{(isa_pkg::XLEN-isa_pkg::NB_IMM){imm16[15]}}, imm16};
        endcase
    end

    // ************************************************************************
    // decode to execute register
    // ************************************************************************
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_dx.valid <= 1'b0;
        end else begin
            o_dx.valid <= i_instr_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_instr_valid) begin
            o_dx.alu_op      <= alu_op;
            o_dx.alu_src_imm <= alu_src_imm;
            o_dx.op_a        <= rs_data;
            o_dx.op_b        <= rt_data;
            o_dx.imm         <= imm_ext;
            o_dx.shamt       <= i_instr[10:6];
            o_dx.mem_read    <= mem_read;
            o_dx.mem_write   <= mem_write;
            o_dx.signed_load <= signed_load;
            o_dx.size        <= size;
            o_dx.reg_write   <= reg_write;
            o_dx.dest        <= dest;
        end
    end

endmodule

/* control_unit.sv */
`timescale 1ns/100ps

module control_unit (
    input  logic [isa_pkg::XLEN-1:0]   i_instr,
    output pipe_pkg::alu_op_e          o_alu_op,
    output logic                       o_alu_src_imm,
    output logic                       o_mem_read,
    output logic                       o_mem_write,
    output logic                       o_reg_write,
    output logic                       o_signed_load,
    output pipe_pkg::ext_mode_e        o_ext_mode,
    output pipe_pkg::size_e            o_size,
    output logic [isa_pkg::NB_REG-1:0] o_dest
);

    isa_pkg::opcode_e           opcode;
    isa_pkg::funct_e            funct;
    logic [isa_pkg::NB_REG-1:0] rt;
    logic [isa_pkg::NB_REG-1:0] rd;

    assign opcode = isa_pkg::opcode_e'(i_instr[31:26]);
    assign funct  = isa_pkg::funct_e'(i_instr[5:0]);
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];

    always_comb begin
        // defaults give an instruction with no effect
        o_alu_op      = pipe_pkg::ALU_ADD;
        o_alu_src_imm = 1'b0;
        o_mem_read    = 1'b0;
        o_mem_write   = 1'b0;
        o_reg_write   = 1'b0;
        o_signed_load = 1'b0;
        o_ext_mode    = pipe_pkg::EXT_SIGNED;
        o_size        = pipe_pkg::SIZE_WORD;
        o_dest        = '0;

        case (opcode)
            isa_pkg::OP_RTYPE: begin
                o_dest      = rd;
                o_reg_write = 1'b1;
                case (funct)
                    isa_pkg::FN_ADD: o_alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUB: o_alu_op = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND: o_alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::FN_OR:  o_alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::FN_XOR: o_alu_op = pipe_pkg::ALU_XOR;
                    isa_pkg::FN_NOR: o_alu_op = pipe_pkg::ALU_NOR;
                    isa_pkg::FN_SLT: o_alu_op = pipe_pkg::ALU_SLT;
                    isa_pkg::FN_SLL: o_alu_op = pipe_pkg::ALU_SLL;
                    isa_pkg::FN_SRL: o_alu_op = pipe_pkg::ALU_SRL;
                    default:         o_reg_write = 1'b0;   // unknown function is dropped
                endcase
            end
            isa_pkg::OP_ADDI, isa_pkg::OP_SLTI: begin
                o_alu_op      = (opcode == isa_pkg::OP_SLTI) ? pipe_pkg::ALU_SLT
                                                             : pipe_pkg::ALU_ADD;
                o_alu_src_imm = 1'b1;
                o_reg_write   = 1'b1;
                o_dest        = rt;
            end
            isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI: begin
                case (opcode)
                    isa_pkg::OP_ANDI: o_alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::OP_ORI:  o_alu_op = pipe_pkg::ALU_OR;
                    default:          o_alu_op = pipe_pkg::ALU_XOR;
                endcase
                o_alu_src_imm = 1'b1;
                o_ext_mode    = pipe_pkg::EXT_UNSIGNED;
                o_reg_write   = 1'b1;
                o_dest        = rt;
            end
            isa_pkg::OP_LUI: begin
                o_alu_op      = pipe_pkg::ALU_LUI_PASS;   // no memory read here
                o_alu_src_imm = 1'b1;
                o_ext_mode    = pipe_pkg::EXT_SHIFT16L;
                o_reg_write   = 1'b1;
                o_dest        = rt;
            end
            isa_pkg::OP_LB, isa_pkg::OP_LBU, isa_pkg::OP_LW: begin
                o_alu_src_imm = 1'b1;
                o_mem_read    = 1'b1;
                o_reg_write   = 1'b1;
                o_signed_load = (opcode != isa_pkg::OP_LBU);
                o_size        = (opcode == isa_pkg::OP_LW) ? pipe_pkg::SIZE_WORD
                                                           : pipe_pkg::SIZE_BYTE;
                o_dest        = rt;
            end
            isa_pkg::OP_SB, isa_pkg::OP_SW: begin
                o_alu_src_imm = 1'b1;
                o_mem_write   = 1'b1;
                o_size        = (opcode == isa_pkg::OP_SW) ? pipe_pkg::SIZE_WORD
                                                           : pipe_pkg::SIZE_BYTE;
            end
            default: ;   // branches, jump and unknown opcodes keep the defaults
        endcase
    end

endmodule

/* stage_ifs.sv */
`timescale 1ns/100ps

// decode to execute
interface dx_if;
    logic                         valid;
    pipe_pkg::alu_op_e            alu_op;
    logic                         alu_src_imm;
    logic [isa_pkg::XLEN-1:0]     op_a;
    logic [isa_pkg::XLEN-1:0]     op_b;
    logic [isa_pkg::XLEN-1:0]     imm;
    logic [isa_pkg::NB_SHAMT-1:0] shamt;
    logic                         mem_read;
    logic                         mem_write;
    logic                         signed_load;
    pipe_pkg::size_e              size;
    logic                         reg_write;
    logic [isa_pkg::NB_REG-1:0]   dest;

    modport src (output valid, alu_op, alu_src_imm, op_a, op_b, imm, shamt,
                 mem_read, mem_write, signed_load, size, reg_write, dest);
    modport dst (input valid, alu_op, alu_src_imm, op_a, op_b, imm, shamt,
                 mem_read, mem_write, signed_load, size, reg_write, dest);
endinterface

// execute to memory
interface xm_if;
    logic                       valid;
    logic [isa_pkg::XLEN-1:0]   result;
    logic [isa_pkg::XLEN-1:0]   store_data;
    logic                       mem_read;
    logic                       mem_write;
    logic                       signed_load;
    pipe_pkg::size_e            size;
    logic                       reg_write;
    logic [isa_pkg::NB_REG-1:0] dest;

    modport src (output valid, result, store_data, mem_read, mem_write,
                 signed_load, size, reg_write, dest);
    modport dst (input valid, result, store_data, mem_read, mem_write,
                 signed_load, size, reg_write, dest);
endinterface

// memory to register file
interface wb_if;
    logic                       valid;
    logic                       reg_write;
    logic [isa_pkg::NB_REG-1:0] dest;
    logic [isa_pkg::XLEN-1:0]   data;

    modport src (output valid, reg_write, dest, data);
    modport dst (input valid, reg_write, dest, data);
endinterface

/* pipe_pkg.sv */
package pipe_pkg;

    // ************************************************************************
    // datapath control encodings
    // ************************************************************************
    typedef enum logic [3:0] {
        ALU_ADD      = 4'd0,
        ALU_SUB      = 4'd1,
        ALU_AND      = 4'd2,
        ALU_OR       = 4'd3,
        ALU_XOR      = 4'd4,
        ALU_NOR      = 4'd5,
        ALU_SLT      = 4'd6,
        ALU_SLL      = 4'd7,
        ALU_SRL      = 4'd8,
        ALU_LUI_PASS = 4'd9       // operand b goes straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        EXT_SIGNED   = 2'd0,
        EXT_UNSIGNED = 2'd1,
        EXT_SHIFT16L = 2'd2
    } ext_mode_e;

    typedef enum logic {
        SIZE_BYTE = 1'b0,
        SIZE_WORD = 1'b1
    } size_e;

    // ************************************************************************
    // data memory geometry
    // ************************************************************************
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = 6;

endpackage

/* isa_pkg.sv */
package isa_pkg;

    // ************************************************************************
    // instruction field widths
    // ************************************************************************
    localparam int XLEN      = 32;
    localparam int NB_REG    = 5;
    localparam int NUM_REGS  = 32;
    localparam int NB_OPCODE = 6;
    localparam int NB_FUNCT  = 6;
    localparam int NB_IMM    = 16;
    localparam int NB_SHAMT  = 5;

    // ************************************************************************
    // primary opcodes, instr[31:26]
    // ************************************************************************
    typedef enum logic [NB_OPCODE-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_SB    = 6'h28,
        OP_SW    = 6'h2b
    } opcode_e;

    // function field of R-type, instr[5:0]
    typedef enum logic [NB_FUNCT-1:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_NOR = 6'h27,
        FN_SLT = 6'h2a
    } funct_e;

endpackage
